// ==== decode.f ====
decode_pkg.sv
field_split.sv
pipe_fifo.sv
uop_decode.sv
decode_top.sv
decode_sva.sv
decode_checker.sv
decode_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= decode_tb
FILELIST  ?= decode.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== decode_tb.sv ====
// Testbench top for decode_top
// REP MOVS is only sent with the pipeline drained, after ecx is loaded
`timescale 1ns/1ns
`default_nettype none

module decode_tb import decode_pkg::*; ();

   localparam logic [31:0] SEED        = 32'hd76c8b12;
   localparam int          N_TOTAL     = 340;
   localparam int          CYCLE_LIMIT = 40 * N_TOTAL + 200;

   logic        ret_near;
   logic        ret_far;
   logic        in_valid;
   logic        in_ready;
   raw_inst_t   in_inst;
   logic        out_valid;
   logic        out_ready;
   uop_t        out_uop;
   logic [31:0] ecx;
   logic        wb_valid;
   logic [2:0]  wb_reg;
   logic [31:0] wb_data;
   logic        ecx_load;
   logic [31:0] ecx_set;
   logic [31:0] ecx_next;
   logic        bp_mode;
   logic        idle;
   int          errors;
   int          checks;
   int          test_id;
   int          issued;
   int          cycles;
   int          errs_before;

   decode_top UUT (
      .ret_near  (ret_near),
      .ret_far   (ret_far),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_inst   (in_inst),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_uop   (out_uop),
      .ecx       (ecx),
      .wb_valid  (wb_valid),
      .wb_reg    (wb_reg),
      .wb_data   (wb_data)
   );

   decode_checker u_chk (
      .ret_near  (ret_near),
      .ret_far   (ret_far),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_inst   (in_inst),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_uop   (out_uop),
      .ecx       (ecx),
      .wb_valid  (wb_valid),
      .wb_reg    (wb_reg),
      .wb_data   (wb_data),
      .test_id   (test_id),
      .idle      (idle),
      .errors    (errors),
      .checks    (checks)
   );

   always #5 ret_near = ~ret_near;

   // ECX register model
   always @(posedge ret_near) begin
      if (ecx_load)
         ecx_next = ecx_set;
      else if (wb_valid)
         ecx_next = wb_data;
      else
         ecx_next = ecx;
      #1;
      ecx = ecx_next;
   end

   always @(posedge ret_near) begin
      #1;
      out_ready = bp_mode ? 1'($urandom_range(0, 1)) : 1'b1;
   end

   always @(posedge ret_near) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles with %0d instructions issued", cycles, issued);
         $display("** FAIL **");
         $finish;
      end
   end

   function automatic raw_inst_t random_inst(input logic [7:0] op);
      raw_inst_t r;
      r.prefix       = 24'($urandom);
      r.prefix_bytes = 2'd0;
      r.opcode       = {op, 8'($urandom)};
      r.opcode_bytes = 2'd1;
      r.modrm        = 8'($urandom);
      r.sib          = 8'($urandom);
      r.disp_imm     = {$urandom, $urandom};
      r.disp_bytes   = 4'($urandom_range(0, 4));
      r.imm_bytes    = 4'($urandom_range(0, 4));
      r.pc           = $urandom;
      return r;
   endfunction

   function automatic logic [7:0] class_opcode();
      case ($urandom_range(0, 6))
         0:       return 8'h01;
         1:       return 8'h03;
         2:       return 8'h89;
         3:       return 8'h8b;
         4:       return 8'hb8 | 8'($urandom_range(0, 7));
         5:       return 8'h50 | 8'($urandom_range(0, 7));
         default: return 8'h58 | 8'($urandom_range(0, 7));
      endcase
   endfunction

   function automatic logic [7:0] any_opcode();
      case ($urandom_range(0, 9))
         0, 1, 2: return class_opcode();
         3:       return 8'hc3;
         4:       return 8'hca;
         5:       return 8'hcf;
         6:       return 8'hfd;
         7:       return 8'ha5;
         default: return 8'($urandom);
      endcase
   endfunction

   function automatic logic [7:0] prefix_byte();
      case ($urandom_range(0, 8))
         0:       return PFX_ES;
         1:       return PFX_CS;
         2:       return PFX_SS;
         3:       return PFX_DS;
         4:       return PFX_FS;
         5:       return PFX_GS;
         6:       return PFX_OPSIZE;
         7:       return PFX_REP;
         default: return 8'($urandom);
      endcase
   endfunction

   task automatic send(input raw_inst_t r);
      logic ok;
      in_inst  = r;
      in_valid = 1'b1;
      ok       = 1'b0;
      while (!ok) begin
         @(negedge ret_near);
         ok = in_ready;
         @(posedge ret_near);
         #1;
      end
      in_valid = 1'b0;
      issued++;
   endtask

   task automatic set_ecx(input logic [31:0] v);
      ecx_load = 1'b1;
      ecx_set  = v;
      @(posedge ret_near);
      #1;
      ecx_load = 1'b0;
   endtask

   task automatic drain();
      do
         @(posedge ret_near);
      while (!idle);
      #1;
   endtask

   task automatic finish_test(input string name);
      drain();
      $display("test %-14s done, %0d errors", name, errors - errs_before);
      errs_before = errors;
   endtask

   initial begin
      raw_inst_t r;
      logic [7:0] op;
      void'($urandom(SEED));
      ret_near    = 1'b0;
      ret_far     = 1'b1;
      in_valid    = 1'b0;
      in_inst     = '0;
      out_ready   = 1'b1;
      ecx         = 32'd0;
      ecx_load    = 1'b0;
      ecx_set     = 32'd0;
      bp_mode     = 1'b0;
      test_id     = 0;
      issued      = 0;
      cycles      = 0;
      errs_before = 0;
      repeat (3) @(posedge ret_near);
      #1;
      ret_far = 1'b0;

      test_id = 1;
      for (int i = 0; i < 40; i++)
         send(random_inst(class_opcode()));
      finish_test("opcode_classes");

      test_id = 2;
      for (int i = 0; i < 40; i++) begin
         op = any_opcode();
         r  = random_inst(op);
         r.prefix       = {prefix_byte(), prefix_byte(), prefix_byte()};
         r.prefix_bytes = (op == OP_MOVSD) ? 2'd0 : 2'($urandom_range(0, 3));
         r.opcode_bytes = 2'($urandom_range(1, 2));
         send(r);
      end
      finish_test("prefixes");

      test_id = 3;
      for (int i = 0; i < 30; i++)
         send(random_inst(class_opcode()));
      finish_test("disp_imm");

      test_id = 4;
      for (int i = 0; i < 20; i++) begin
         case (i % 7)
            0:       op = 8'hc3;
            1:       op = 8'hc2;
            2:       op = 8'hcb;
            3:       op = 8'hca;
            4:       op = 8'hcf;
            5:       op = 8'hfc;
            default: op = 8'hfd;
         endcase
         send(random_inst(op));
      end
      finish_test("control_ops");

      test_id = 5;
      for (int i = 0; i < 5; i++) begin
         set_ecx((i < 2) ? 32'(i) : 32'($urandom_range(2, 6)));
         r = random_inst(OP_MOVSD);
         r.prefix       = {PFX_REP, prefix_byte(), 8'h00};
         r.prefix_bytes = 2'($urandom_range(1, 2));
         send(r);
         send(random_inst(class_opcode()));
         drain();
      end
      finish_test("rep_movs");

      test_id = 6;
      bp_mode = 1'b1;
      for (int i = 0; i < 200; i++) begin
         repeat ($urandom_range(0, 2)) @(posedge ret_near);
         #1;
         send(random_inst(any_opcode()));
      end
      finish_test("back_pressure");
      bp_mode = 1'b0;

      $display("%0d instructions, %0d checks, %0d errors", issued, checks, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

// ==== decode_checker.sv ====
// Watches the decode_top ports and compares against a reference model
// All ports are sampled on the falling edge, between transfers
// REP MOVS repeat count is taken from ecx when the instruction is accepted
`timescale 1ns/1ns
`default_nettype none

module decode_checker import decode_pkg::*; (
   input  logic        ret_near,
   input  logic        ret_far,
   input  logic        in_valid,
   input  logic        in_ready,
   input  raw_inst_t   in_inst,
   input  logic        out_valid,
   input  logic        out_ready,
   input  uop_t        out_uop,
   input  logic [31:0] ecx,
   input  logic        wb_valid,
   input  logic [2:0]  wb_reg,
   input  logic [31:0] wb_data,
   input  int          test_id,
   output logic        idle,
   output int          errors,
   output int          checks
);

   uop_t        exp_q[$];
   logic [31:0] wb_q[$];
   uop_t        pred;
   uop_t        exp_uop;
   logic [31:0] exp_wb;
   logic [31:0] k;

   function automatic string test_label(input int id);
      case (id)
         1:       return "opcode_classes";
         2:       return "prefixes";
         3:       return "disp_imm";
         4:       return "control_ops";
         5:       return "rep_movs";
         6:       return "back_pressure";
         default: return "setup";
      endcase
   endfunction

   function automatic logic [31:0] low_bytes(input logic [31:0] v, input logic [3:0] n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < 4; i++)
         if (i < n)
            r[8*i +: 8] = v[8*i +: 8];
      return r;
   endfunction

   function automatic logic is_rep_movs(input raw_inst_t r);
      logic rep;
      rep = 1'b0;
      for (int i = 0; i < r.prefix_bytes; i++)
         if (r.prefix[23-8*i -: 8] == PFX_REP)
            rep = 1'b1;
      return rep && (r.opcode[15:8] == OP_MOVSD);
   endfunction

   function automatic uop_t predict_uop(input raw_inst_t r);
      uop_t        u;
      logic [7:0]  op;
      logic [7:0]  pb;
      logic [63:0] rest;
      logic        mem;
      u    = '0;
      op   = r.opcode[15:8];
      mem  = (r.modrm[7:6] != 2'b11);
      rest = r.disp_imm >> (8 * r.disp_bytes);
      u.opcode = (r.opcode_bytes == 2'd1) ? {op, 8'h00} : r.opcode;
      u.size   = SIZE_32;
      u.disp   = low_bytes(r.disp_imm[31:0], r.disp_bytes);
      u.imm    = low_bytes(rest[31:0], r.imm_bytes);
      u.pc     = r.pc;
      // First prefix first, so a later override replaces it
      for (int i = 0; i < r.prefix_bytes; i++) begin
         pb = r.prefix[23-8*i -: 8];
         if (pb == PFX_OPSIZE)
            u.size = SIZE_16;
         else if (pb == PFX_ES || pb == PFX_CS || pb == PFX_SS ||
                  pb == PFX_DS || pb == PFX_FS || pb == PFX_GS) begin
            u.seg_valid = 1'b1;
            case (pb)
               PFX_ES:  u.seg_override = SEG_ES;
               PFX_CS:  u.seg_override = SEG_CS;
               PFX_SS:  u.seg_override = SEG_SS;
               PFX_DS:  u.seg_override = SEG_DS;
               PFX_FS:  u.seg_override = SEG_FS;
               default: u.seg_override = SEG_GS;
            endcase
         end
      end
      if (op == 8'h01 || op == 8'h89) begin
         u.alu_op   = (op == 8'h01) ? ALU_ADD : ALU_MOV;
         u.op0_kind = mem ? OPND_MEM : OPND_REG;
         u.op0_reg  = r.modrm[2:0];
         u.op1_kind = OPND_REG;
         u.op1_reg  = r.modrm[5:3];
      end else if (op == 8'h03 || op == 8'h8b) begin
         u.alu_op   = (op == 8'h03) ? ALU_ADD : ALU_MOV;
         u.op0_kind = OPND_REG;
         u.op0_reg  = r.modrm[5:3];
         u.op1_kind = mem ? OPND_MEM : OPND_REG;
         u.op1_reg  = r.modrm[2:0];
      end else if (op[7:3] == 5'b10111) begin
         u.alu_op   = ALU_MOV;
         u.op0_kind = OPND_REG;
         u.op0_reg  = op[2:0];
         u.op1_kind = OPND_IMM;
      end else if (op[7:3] == 5'b01010 || op[7:3] == 5'b01011) begin
         u.alu_op   = op[3] ? ALU_POP : ALU_PUSH;
         u.op0_kind = OPND_REG;
         u.op0_reg  = op[2:0];
         u.stack_op = op[3] ? STACK_POP : STACK_PUSH;
      end else if (op == 8'ha5) begin
         u.alu_op = ALU_MOVS;
      end else if (op == 8'hc3 || op == 8'hc2) begin
         u.alu_op      = ALU_RET;
         u.is_ret_near = 1'b1;
      end else if (op == 8'hcb || op == 8'hca) begin
         u.alu_op     = ALU_RET;
         u.is_ret_far = 1'b1;
      end else if (op == 8'hcf) begin
         u.alu_op   = ALU_RET;
         u.is_iretd = 1'b1;
      end else if (op == 8'hfc) begin
         u.alu_op  = ALU_CLD;
         u.clear_d = 1'b1;
      end else if (op == 8'hfd) begin
         u.alu_op = ALU_STD;
         u.set_d  = 1'b1;
      end
      return u;
   endfunction

   initial begin
      errors = 0;
      checks = 0;
      idle   = 1'b1;
   end

   always @(negedge ret_near) begin
      if (!ret_far) begin
         if (in_valid && in_ready) begin
            pred = predict_uop(in_inst);
            if (is_rep_movs(in_inst)) begin
               for (k = ecx; k != 0; k--) begin
                  exp_q.push_back(pred);
                  wb_q.push_back(k - 32'd1);
               end
            end else begin
               exp_q.push_back(pred);
            end
         end
         if (wb_valid) begin
            checks++;
            if (wb_q.size() == 0) begin
               errors++;
               $display("Unexpected ECX writeback of %h in test %s", wb_data,
                        test_label(test_id));
            end else begin
               exp_wb = wb_q.pop_front();
               if (wb_data !== exp_wb || wb_reg !== ECX_REG) begin
                  errors++;
                  $display("[FAIL] %s: expected %h, actual %h", test_label(test_id),
                           exp_wb, wb_data);
               end
            end
         end
         if (out_valid && out_ready) begin
            checks++;
            if (exp_q.size() == 0) begin
               errors++;
               $display("Micro-op delivered with none expected in test %s",
                        test_label(test_id));
            end else begin
               exp_uop = exp_q.pop_front();
               if (out_uop !== exp_uop) begin
                  errors++;
                  $display("[FAIL] %s: expected %h, actual %h", test_label(test_id),
                           exp_uop, out_uop);
               end
            end
         end
      end
      idle = (exp_q.size() == 0) && (wb_q.size() == 0);
   end

endmodule

`default_nettype wire

// ==== decode_sva.sv ====
// Handshake and reset checks, bound into decode_top
// Reset check is sampled on ret_near, so the clock must run during reset
`timescale 1ns/1ns
`default_nettype none

module decode_sva import decode_pkg::*; (
   input logic       ret_near,
   input logic       ret_far,
   input logic       in_ready,
   input logic       split_valid,
   input logic       dq_valid,
   input logic       uop_valid,
   input uop_t       uop,
   input logic       out_valid,
   input logic       out_ready,
   input uop_t       out_uop,
   input logic       wb_valid,
   input logic [2:0] wb_reg
);

   // Output held while stalled
   a_out_stable: assert property (@(posedge ret_near) disable iff (ret_far)
      out_valid && !out_ready |=> out_valid && $stable(out_uop))
      else $error("out_valid or out_uop changed while out_ready was low");

   // A writeback goes with a MOVS micro-op loaded into the decoder output
   a_wb_reg: assert property (@(posedge ret_near) disable iff (ret_far)
      wb_valid |=> uop_valid && uop.alu_op == ALU_MOVS && $past(wb_reg) == ECX_REG)
      else $error("ECX writeback without a MOVS micro-op, or not to ECX");

   a_reset_quiet: assert property (@(posedge ret_near)
      ret_far |-> !in_ready && !split_valid && !dq_valid && !uop_valid && !out_valid
                  && !wb_valid)
      else $error("valid or ready high during reset");

endmodule

bind decode_top decode_sva u_sva (
   .ret_near    (ret_near),
   .ret_far     (ret_far),
   .in_ready    (in_ready),
   .split_valid (split_valid),
   .dq_valid    (dq_valid),
   .uop_valid   (uop_valid),
   .uop         (uop),
   .out_valid   (out_valid),
   .out_ready   (out_ready),
   .out_uop     (out_uop),
   .wb_valid    (wb_valid),
   .wb_reg      (wb_reg)
);

`default_nettype wire

// ==== decode_top.sv ====
// Splitter, input FIFO, micro-op decoder and output FIFO in a chain
// ecx is owned outside and must follow the wb_* writeback
`timescale 1ns/1ns
`default_nettype none

module decode_top import decode_pkg::*; (
   input  logic        ret_near,
   input  logic        ret_far,
   input  logic        in_valid,
   output logic        in_ready,
   input  raw_inst_t   in_inst,
   output logic        out_valid,
   input  logic        out_ready,
   output uop_t        out_uop,
   input  logic [31:0] ecx,
   output logic        wb_valid,
   output logic [2:0]  wb_reg,
   output logic [31:0] wb_data
);

   logic        split_valid;
   logic        split_ready;
   split_inst_t split_inst;
   logic        dq_valid;
   logic        dq_ready;
   split_inst_t dq_inst;
   logic        uop_valid;
   logic        uop_ready;
   uop_t        uop;

   field_split u_split (
      .ret_near    (ret_near),
      .ret_far     (ret_far),
      .in_valid    (in_valid),
      .in_ready    (in_ready),
      .in_inst     (in_inst),
      .split_valid (split_valid),
      .split_ready (split_ready),
      .split_inst  (split_inst)
   );

   pipe_fifo #(.payload_t(split_inst_t)) u_in_fifo (
      .ret_near (ret_near),
      .ret_far  (ret_far),
      .wr_valid (split_valid),
      .wr_ready (split_ready),
      .wr_data  (split_inst),
      .rd_valid (dq_valid),
      .rd_ready (dq_ready),
      .rd_data  (dq_inst)
   );

   uop_decode u_decode (
      .ret_near  (ret_near),
      .ret_far   (ret_far),
      .dq_valid  (dq_valid),
      .dq_ready  (dq_ready),
      .dq_inst   (dq_inst),
      .ecx       (ecx),
      .uop_valid (uop_valid),
      .uop_ready (uop_ready),
      .uop       (uop),
      .wb_valid  (wb_valid),
      .wb_reg    (wb_reg),
      .wb_data   (wb_data)
   );

   pipe_fifo #(.payload_t(uop_t)) u_out_fifo (
      .ret_near (ret_near),
      .ret_far  (ret_far),
      .wr_valid (uop_valid),
      .wr_ready (uop_ready),
      .wr_data  (uop),
      .rd_valid (out_valid),
      .rd_ready (out_ready),
      .rd_data  (out_uop)
   );

endmodule

`default_nettype wire

// ==== uop_decode.sv ====
// One micro-op per instruction, except REP MOVS which repeats ecx times
// ecx must reflect the previous writeback by the next edge
// wb_valid is combinational with the load of the output register
`timescale 1ns/1ns
`default_nettype none

module uop_decode import decode_pkg::*; (
   input  logic        ret_near,
   input  logic        ret_far,
   input  logic        dq_valid,
   output logic        dq_ready,
   input  split_inst_t dq_inst,
   input  logic [31:0] ecx,
   output logic        uop_valid,
   input  logic        uop_ready,
   output uop_t        uop,
   output logic        wb_valid,
   output logic [2:0]  wb_reg,
   output logic [31:0] wb_data
);

   logic out_free;
   logic rep_movs;
   logic ecx_zero;
   logic ecx_last;
   logic load;
   uop_t next_uop;

   function automatic uop_t decode_uop(input split_inst_t si);
      uop_t       u;
      logic [7:0] op;
      logic       mem_rm;
      op     = si.opcode[15:8];
      mem_rm = (si.modrm[7:6] != 2'b11);

      u.alu_op       = ALU_NONE;
      u.op0_kind     = OPND_NONE;
      u.op0_reg      = 3'd0;
      u.op1_kind     = OPND_NONE;
      u.op1_reg      = 3'd0;
      u.size         = si.size_16 ? SIZE_16 : SIZE_32;
      u.set_d        = 1'b0;
      u.clear_d      = 1'b0;
      u.stack_op     = STACK_NONE;
      u.is_ret_near  = 1'b0;
      u.is_ret_far   = 1'b0;
      u.is_iretd     = 1'b0;
      u.seg_override = si.seg_override;
      u.seg_valid    = si.seg_valid;
      u.imm          = si.imm;
      u.disp         = si.disp;
      u.pc           = si.pc;
      u.opcode       = si.opcode;

      case (op) inside
         // r/m is the destination
         OP_ADD_RM_R, OP_MOV_RM_R: begin
            u.alu_op   = (op == OP_ADD_RM_R) ? ALU_ADD : ALU_MOV;
            u.op0_kind = mem_rm ? OPND_MEM : OPND_REG;
            u.op0_reg  = si.modrm[2:0];
            u.op1_kind = OPND_REG;
            u.op1_reg  = si.modrm[5:3];
         end
         OP_ADD_R_RM, OP_MOV_R_RM: begin
            u.alu_op   = (op == OP_ADD_R_RM) ? ALU_ADD : ALU_MOV;
            u.op0_kind = OPND_REG;
            u.op0_reg  = si.modrm[5:3];
            u.op1_kind = mem_rm ? OPND_MEM : OPND_REG;
            u.op1_reg  = si.modrm[2:0];
         end
         [OP_MOV_IMM : OP_MOV_IMM + 8'd7]: begin
            u.alu_op   = ALU_MOV;
            u.op0_kind = OPND_REG;
            u.op0_reg  = op[2:0];
            u.op1_kind = OPND_IMM;
         end
         [OP_PUSH : OP_PUSH + 8'd7]: begin
            u.alu_op   = ALU_PUSH;
            u.op0_kind = OPND_REG;
            u.op0_reg  = op[2:0];
            u.stack_op = STACK_PUSH;
         end
         [OP_POP : OP_POP + 8'd7]: begin
            u.alu_op   = ALU_POP;
            u.op0_kind = OPND_REG;
            u.op0_reg  = op[2:0];
            u.stack_op = STACK_POP;
         end
         OP_MOVSD:
            u.alu_op = ALU_MOVS;
         OP_RET_NEAR, OP_RET_NEAR_IMM: begin
            u.alu_op      = ALU_RET;
            u.is_ret_near = 1'b1;
         end
         OP_RET_FAR, OP_RET_FAR_IMM: begin
            u.alu_op     = ALU_RET;
            u.is_ret_far = 1'b1;
         end
         OP_IRETD: begin
            u.alu_op   = ALU_RET;
            u.is_iretd = 1'b1;
         end
         OP_CLD: begin
            u.alu_op  = ALU_CLD;
            u.clear_d = 1'b1;
         end
         OP_STD: begin
            u.alu_op = ALU_STD;
            u.set_d  = 1'b1;
         end
         default: u.alu_op = ALU_NONE;
      endcase
      return u;
   endfunction

   assign next_uop = decode_uop(dq_inst);

   assign out_free = !uop_valid || uop_ready;
   assign rep_movs = dq_inst.rep && (dq_inst.opcode[15:8] == OP_MOVSD);
   assign ecx_zero = (ecx == 32'd0);
   assign ecx_last = (ecx == 32'd1);

   // A zero count REP MOVS is dropped without issue
   assign load     = dq_valid && out_free && !(rep_movs && ecx_zero);
   assign dq_ready = rep_movs ? (ecx_zero || (out_free && ecx_last)) : out_free;

   assign wb_valid = load && rep_movs;
   assign wb_reg   = ECX_REG;
   assign wb_data  = ecx - 32'd1;

   always_ff @(posedge ret_near or posedge ret_far) begin
      if (ret_far)
         uop_valid <= 1'b0;
      else if (out_free)
         uop_valid <= load;
   end

   always_ff @(posedge ret_near) begin
      if (load)
         uop <= next_uop;
   end

endmodule

`default_nettype wire

// ==== pipe_fifo.sv ====
// Depth comes from FIFO_DEPTH in the package
// Read data is the entry at the head, one cycle after its write
`timescale 1ns/1ns
`default_nettype none

module pipe_fifo import decode_pkg::*; #(
   parameter type payload_t = logic [7:0]
) (
   input  logic     ret_near,
   input  logic     ret_far,
   input  logic     wr_valid,
   output logic     wr_ready,
   input  payload_t wr_data,
   output logic     rd_valid,
   input  logic     rd_ready,
   output payload_t rd_data
);

   payload_t              mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [FIFO_CNT_W-1:0] count;
   logic                  push;
   logic                  pop;

   function automatic logic [FIFO_PTR_W-1:0] ptr_inc(input logic [FIFO_PTR_W-1:0] p);
      return (p == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign wr_ready = (count != FIFO_CNT_W'(FIFO_DEPTH));
   assign rd_valid = (count != '0);
   assign push     = wr_valid && wr_ready;
   assign pop      = rd_valid && rd_ready;
   assign rd_data  = mem[rd_ptr];

   always_ff @(posedge ret_near or posedge ret_far) begin
      if (ret_far) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= ptr_inc(wr_ptr);
         if (pop)
            rd_ptr <= ptr_inc(rd_ptr);
         // Simultaneous push and pop leaves the count alone
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge ret_near) begin
      if (push)
         mem[wr_ptr] <= wr_data;
   end

endmodule

`default_nettype wire

// ==== field_split.sv ====
// Prefix and opcode bytes arrive left aligned, the first byte on top
// Disp and imm counts above 4 saturate at 4 bytes
// in_ready stays low until the first edge after reset
`timescale 1ns/1ns
`default_nettype none

module field_split import decode_pkg::*; (
   input  logic        ret_near,
   input  logic        ret_far,
   input  logic        in_valid,
   output logic        in_ready,
   input  raw_inst_t   in_inst,
   output logic        split_valid,
   input  logic        split_ready,
   output split_inst_t split_inst
);

   logic        running;
   logic [23:0] mask_prefix;
   logic [15:0] mask_op;
   seg_t        seg;
   logic        seg_valid;
   logic        rep;
   logic        size_16;
   logic [63:0] imm_field;
   split_inst_t next_inst;

   function automatic logic [31:0] byte_mask(input logic [3:0] n);
      logic [31:0] m;
      case (n)
         4'd0:    m = 32'h0000_0000;
         4'd1:    m = 32'h0000_00ff;
         4'd2:    m = 32'h0000_ffff;
         4'd3:    m = 32'h00ff_ffff;
         default: m = 32'hffff_ffff;
      endcase
      return m;
   endfunction

   // Drop bytes past the counts
   always_comb begin
      case (in_inst.prefix_bytes)
         2'd0:    mask_prefix = 24'h0;
         2'd1:    mask_prefix = {in_inst.prefix[23:16], 16'h0};
         2'd2:    mask_prefix = {in_inst.prefix[23:8], 8'h0};
         default: mask_prefix = in_inst.prefix;
      endcase
   end

   assign mask_op = (in_inst.opcode_bytes >= 2'd2) ? in_inst.opcode :
                    {in_inst.opcode[15:8], 8'h00};

   // Walk from the first prefix to the last so a later override wins
   always_comb begin
      logic [7:0] pb;
      logic       hit;
      seg_t       nseg;
      seg       = SEG_ES;
      seg_valid = 1'b0;
      rep       = 1'b0;
      size_16   = 1'b0;
      for (int i = 2; i >= 0; i--) begin
         pb  = mask_prefix[i*8 +: 8];
         hit = 1'b1;
         case (pb)
            PFX_ES:  nseg = SEG_ES;
            PFX_CS:  nseg = SEG_CS;
            PFX_SS:  nseg = SEG_SS;
            PFX_DS:  nseg = SEG_DS;
            PFX_FS:  nseg = SEG_FS;
            PFX_GS:  nseg = SEG_GS;
            default: begin
               hit  = 1'b0;
               nseg = seg;
            end
         endcase
         if (hit) begin
            seg       = nseg;
            seg_valid = 1'b1;
         end
         if (pb == PFX_REP)
            rep = 1'b1;
         if (pb == PFX_OPSIZE)
            size_16 = 1'b1;
      end
   end

   // Immediate follows the displacement bytes
   assign imm_field = in_inst.disp_imm >> {in_inst.disp_bytes, 3'b000};

   always_comb begin
      next_inst.opcode       = mask_op;
      next_inst.modrm        = in_inst.modrm;
      next_inst.sib          = in_inst.sib;
      next_inst.disp         = in_inst.disp_imm[31:0] & byte_mask(in_inst.disp_bytes);
      next_inst.imm          = imm_field[31:0] & byte_mask(in_inst.imm_bytes);
      next_inst.seg_override = seg;
      next_inst.seg_valid    = seg_valid;
      next_inst.rep          = rep;
      next_inst.size_16      = size_16;
      next_inst.pc           = in_inst.pc;
   end

   assign in_ready = running && (!split_valid || split_ready);

   always_ff @(posedge ret_near or posedge ret_far) begin
      if (ret_far) begin
         running     <= 1'b0;
         split_valid <= 1'b0;
      end else begin
         running <= 1'b1;
         if (in_ready)
            split_valid <= in_valid;
      end
   end

   always_ff @(posedge ret_near) begin
      if (in_valid && in_ready)
         split_inst <= next_inst;
   end

endmodule

`default_nettype wire

// ==== decode_pkg.sv ====
// Types and constants shared by the first decode stage
// Covers only the 32-bit opcode subset listed below; any other opcode decodes to ALU_NONE
`default_nettype none

package decode_pkg;

   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W = FIFO_PTR_W + 1;

   localparam logic [2:0] ECX_REG = 3'd1;

   // Prefix bytes
   localparam logic [7:0] PFX_ES     = 8'h26;
   localparam logic [7:0] PFX_CS     = 8'h2e;
   localparam logic [7:0] PFX_SS     = 8'h36;
   localparam logic [7:0] PFX_DS     = 8'h3e;
   localparam logic [7:0] PFX_FS     = 8'h64;
   localparam logic [7:0] PFX_GS     = 8'h65;
   localparam logic [7:0] PFX_OPSIZE = 8'h66;
   localparam logic [7:0] PFX_REP    = 8'hf3;

   // Primary opcodes, ranges given by their base
   localparam logic [7:0] OP_ADD_RM_R     = 8'h01;
   localparam logic [7:0] OP_ADD_R_RM     = 8'h03;
   localparam logic [7:0] OP_MOV_RM_R     = 8'h89;
   localparam logic [7:0] OP_MOV_R_RM     = 8'h8b;
   localparam logic [7:0] OP_MOV_IMM      = 8'hb8;
   localparam logic [7:0] OP_PUSH         = 8'h50;
   localparam logic [7:0] OP_POP          = 8'h58;
   localparam logic [7:0] OP_MOVSD        = 8'ha5;
   localparam logic [7:0] OP_RET_NEAR     = 8'hc3;
   localparam logic [7:0] OP_RET_NEAR_IMM = 8'hc2;
   localparam logic [7:0] OP_RET_FAR      = 8'hcb;
   localparam logic [7:0] OP_RET_FAR_IMM  = 8'hca;
   localparam logic [7:0] OP_IRETD        = 8'hcf;
   localparam logic [7:0] OP_CLD          = 8'hfc;
   localparam logic [7:0] OP_STD          = 8'hfd;

   // Operand size codes
   localparam logic [1:0] SIZE_16 = 2'd1;
   localparam logic [1:0] SIZE_32 = 2'd2;

   // Stack operation codes
   localparam logic [1:0] STACK_NONE = 2'd0;
   localparam logic [1:0] STACK_PUSH = 2'd1;
   localparam logic [1:0] STACK_POP  = 2'd2;

   typedef enum logic [2:0] {
      SEG_ES = 3'd0,
      SEG_CS = 3'd1,
      SEG_SS = 3'd2,
      SEG_DS = 3'd3,
      SEG_FS = 3'd4,
      SEG_GS = 3'd5
   } seg_t;

   typedef enum logic [3:0] {
      ALU_NONE = 4'd0,
      ALU_ADD  = 4'd1,
      ALU_MOV  = 4'd2,
      ALU_PUSH = 4'd3,
      ALU_POP  = 4'd4,
      ALU_MOVS = 4'd5,
      ALU_RET  = 4'd6,
      ALU_CLD  = 4'd7,
      ALU_STD  = 4'd8
   } alu_op_t;

   typedef enum logic [1:0] {
      OPND_NONE = 2'd0,
      OPND_REG  = 2'd1,
      OPND_MEM  = 2'd2,
      OPND_IMM  = 2'd3
   } opnd_t;

   // As delivered by fetch, multi-byte fields are left aligned
   typedef struct packed {
      logic [23:0] prefix;
      logic [1:0]  prefix_bytes;
      logic [15:0] opcode;
      logic [1:0]  opcode_bytes;
      logic [7:0]  modrm;
      logic [7:0]  sib;
      logic [63:0] disp_imm;
      logic [3:0]  disp_bytes;
      logic [3:0]  imm_bytes;
      logic [31:0] pc;
   } raw_inst_t;

   typedef struct packed {
      logic [15:0] opcode;
      logic [7:0]  modrm;
      logic [7:0]  sib;
      logic [31:0] disp;
      logic [31:0] imm;
      seg_t        seg_override;
      logic        seg_valid;
      logic        rep;
      logic        size_16;
      logic [31:0] pc;
   } split_inst_t;

   typedef struct packed {
      alu_op_t     alu_op;
      opnd_t       op0_kind;
      logic [2:0]  op0_reg;
      opnd_t       op1_kind;
      logic [2:0]  op1_reg;
      logic [1:0]  size;
      logic        set_d;
      logic        clear_d;
      logic [1:0]  stack_op;
      logic        is_ret_near;
      logic        is_ret_far;
      logic        is_iretd;
      seg_t        seg_override;
      logic        seg_valid;
      logic [31:0] imm;
      logic [31:0] disp;
      logic [31:0] pc;
      logic [15:0] opcode;
   } uop_t;

endpackage

`default_nettype wire
